// ==== design/addressGen.sv ====
module addressGen (
    input  logic        clk,
    input  logic        reset,
    input  logic        memRead,
    input  logic        memWrite,
    input  logic [31:0] instNum,
    input  logic [2:0]  funct3,
    input  logic [31:0] baseAddr,
    input  logic [31:0] offset,
    input  logic [31:0] storeData,
    input  logic [7:0]  phyIn,
    lsuReqIf.addrSide   req,
    output logic        accessFault
);
    import lsuPkg::*;

    logic [31:0] effAddr;
    logic        loadCode;                          // funct3 is a legal load
    logic        storeCode;                         // funct3 is a legal store
    logic        misaligned;
    logic        readReq;
    logic        writeReq;
    logic        faultPending;                      // Fault waiting for the memory edge

    assign effAddr = baseAddr + offset;

    always_comb begin
        loadCode   = 1'b0;
        storeCode  = 1'b0;
        misaligned = 1'b0;
        case (funct3)
            fnByte: begin
                loadCode  = 1'b1;
                storeCode = 1'b1;
            end
            fnHalf: begin
                loadCode   = 1'b1;
                storeCode  = 1'b1;
                misaligned = effAddr[0];
            end
            fnWord: begin
                loadCode   = 1'b1;
                storeCode  = 1'b1;
                misaligned = |effAddr[1:0];
            end
            fnByteU: loadCode = 1'b1;               // No unsigned stores
            fnHalfU: begin
                loadCode   = 1'b1;
                misaligned = effAddr[0];
            end
            default: ;                              // Unknown code, dropped
        endcase
    end

    // A store wins if both strobes come in together
    assign writeReq = memWrite && storeCode;
    assign readReq  = memRead && !memWrite && loadCode;

    always_ff @(posedge clk) begin
        if (reset) begin
            req.validRead  <= 1'b0;
            req.validWrite <= 1'b0;
            faultPending   <= 1'b0;
            accessFault    <= 1'b0;
        end else begin
            req.validRead  <= readReq && !misaligned;
            req.validWrite <= writeReq && !misaligned;
            faultPending   <= (readReq || writeReq) && misaligned;
            accessFault    <= faultPending;         // Lines up with loadDone
        end
    end

    always_ff @(posedge clk) begin
        req.instNum    <= instNum;
        req.funct3     <= funct3;
        req.wordIndex  <= effAddr[wordIndexBits+1:2]; // Wraps on low bits
        req.byteOffset <= effAddr[1:0];
        req.storeData  <= storeData;
        req.phyTag     <= phyIn;
    end

endmodule

// ==== design/dataMemory.sv ====
module dataMemory (
    input  logic        clk,
    input  logic        reset,
    lsuReqIf.memSide    req,
    output logic [31:0] loadData,
    output logic [31:0] loadInstNum,
    output logic        loadDone,
    output logic [7:0]  loadPhy
);
    import lsuPkg::*;

    memWord_u    mem [memWords];

    memWord_u    curWord;                           // Addressed word as stored
    memWord_u    mergedWord;                        // Word after the store lane merge
    logic [7:0]  byteLane;
    logic [15:0] halfLane;
    logic [31:0] loadValue;                         // Extended load result

    assign curWord = mem[req.wordIndex];

    // Lane picks for loads
    assign byteLane = curWord.bytes[req.byteOffset];
    assign halfLane = curWord.halves[req.byteOffset[1]];

    // Store merge into the addressed lane
    always_comb begin
        mergedWord = curWord;
        case (req.funct3)
            fnByte:  mergedWord.bytes[req.byteOffset]     = req.storeData[7:0];
            fnHalf:  mergedWord.halves[req.byteOffset[1]] = req.storeData[15:0];
            fnWord:  mergedWord.word                      = req.storeData;
            default: mergedWord = curWord;          // Filtered upstream anyway
        endcase
    end

    // Sign or zero extension from the loaded lane itself
    always_comb begin
        case (req.funct3)
            fnByte:  loadValue = {{24{byteLane[7]}}, byteLane};
            fnHalf:  loadValue = {{16{halfLane[15]}}, halfLane};
            fnWord:  loadValue = curWord.word;
            fnByteU: loadValue = {24'd0, byteLane};
            fnHalfU: loadValue = {16'd0, halfLane};
            default: loadValue = 32'd0;
        endcase
    end

    // Storage array, preset so each word holds its index plus 3
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < memWords; i++) begin
                mem[i].word <= 32'(i + 3);
            end
        end else if (req.validWrite) begin
            mem[req.wordIndex] <= mergedWord;
        end
    end

    // Load result register, zero whenever no load is served
    always_ff @(posedge clk) begin
        if (reset) begin
            loadData    <= 32'd0;
            loadInstNum <= 32'd0;
            loadDone    <= 1'b0;
            loadPhy     <= 8'd0;
        end else if (req.validRead) begin
            loadData    <= loadValue;
            loadInstNum <= req.instNum;
            loadDone    <= 1'b1;                    // One cycle pulse
            loadPhy     <= req.phyTag;
        end else begin
            loadData    <= 32'd0;
            loadInstNum <= 32'd0;
            loadDone    <= 1'b0;
            loadPhy     <= 8'd0;
        end
    end

endmodule

// ==== design/loadStoreUnit.sv ====
module loadStoreUnit (
    input  logic        clk,
    input  logic        reset,
    input  logic        memRead,
    input  logic        memWrite,
    input  logic [31:0] instNum,
    input  logic [2:0]  funct3,
    input  logic [31:0] baseAddr,
    input  logic [31:0] offset,
    input  logic [31:0] storeData,
    input  logic [7:0]  phyIn,
    output logic [31:0] loadData,
    output logic [31:0] loadInstNum,
    output logic        loadDone,
    output logic [7:0]  loadPhy,
    output logic        accessFault
);

    // Registered request between the two stages
    lsuReqIf reqBus ();

    addressGen addrStage (
        .clk         (clk),
        .reset       (reset),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .instNum     (instNum),
        .funct3      (funct3),
        .baseAddr    (baseAddr),
        .offset      (offset),
        .storeData   (storeData),
        .phyIn       (phyIn),
        .req         (reqBus.addrSide),
        .accessFault (accessFault)
    );

    dataMemory dataMem (
        .clk         (clk),
        .reset       (reset),
        .req         (reqBus.memSide),
        .loadData    (loadData),
        .loadInstNum (loadInstNum),
        .loadDone    (loadDone),
        .loadPhy     (loadPhy)
    );

endmodule

// ==== design/lsuPkg.sv ====
package lsuPkg;

    // Data memory geometry
    localparam int memWords      = 256;
    localparam int wordIndexBits = 8;               // log2 of memWords

    // funct3 encodings shared by loads and stores
    localparam logic [2:0] fnByte  = 3'b000;        // LB / SB
    localparam logic [2:0] fnHalf  = 3'b001;        // LH / SH
    localparam logic [2:0] fnWord  = 3'b010;        // LW / SW
    localparam logic [2:0] fnByteU = 3'b100;        // LBU
    localparam logic [2:0] fnHalfU = 3'b101;        // LHU

    // One memory word, seen whole or split into lanes.
    // Byte lane n sits at byte offset n, halfword lane n at offset 2n.
    typedef union packed {
        logic [31:0]       word;                    // Full word
        logic [3:0][7:0]   bytes;                   // Byte lanes
        logic [1:0][15:0]  halves;                  // Halfword lanes
    } memWord_u;

endpackage

// ==== design/lsuReqIf.sv ====
interface lsuReqIf;
    import lsuPkg::*;

    logic                     validRead;            // Aligned load accepted
    logic                     validWrite;           // Aligned store accepted
    logic [31:0]              instNum;              // Instruction number
    logic [2:0]               funct3;               // Access width and sign
    logic [wordIndexBits-1:0] wordIndex;            // Wrapped word address
    logic [1:0]               byteOffset;           // Byte within the word
    logic [31:0]              storeData;            // Store payload
    logic [7:0]               phyTag;               // Physical destination tag

    // Address stage drives the registered request
    modport addrSide (
        output validRead,
        output validWrite,
        output instNum,
        output funct3,
        output wordIndex,
        output byteOffset,
        output storeData,
        output phyTag
    );

    // Data memory consumes it one edge later
    modport memSide (
        input validRead,
        input validWrite,
        input instNum,
        input funct3,
        input wordIndex,
        input byteOffset,
        input storeData,
        input phyTag
    );

endinterface

// ==== loadStoreUnit.f ====
design/lsuPkg.sv
design/lsuReqIf.sv
design/addressGen.sv
design/dataMemory.sv
design/loadStoreUnit.sv
verif/lsuProperties.sv
verif/lsuChecker.sv
verif/lsuTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module lsuTb -f loadStoreUnit.f

# The simulation status is judged from its log below
./obj_dir/VlsuTb > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== verif/lsuChecker.sv ====
module lsuChecker (
    input  logic        clk,
    input  logic        reset,
    input  logic        memRead,
    input  logic        memWrite,
    input  logic [31:0] instNum,
    input  logic [2:0]  funct3,
    input  logic [31:0] baseAddr,
    input  logic [31:0] offset,
    input  logic [31:0] storeData,
    input  logic [7:0]  phyIn,
    input  logic [3:0]  testId,
    input  logic [31:0] loadData,
    input  logic [31:0] loadInstNum,
    input  logic        loadDone,
    input  logic [7:0]  loadPhy,
    input  logic        accessFault,
    output int          checkCount,
    output int          errorCount
);
    import lsuPkg::*;

    typedef struct packed {
        logic [3:0]  testId;
        logic        done;
        logic        fault;
        logic [31:0] data;
        logic [31:0] inst;
        logic [7:0]  phy;
    } expEntry_t;

    logic [31:0] shadow [memWords];                 // Model of the data memory
    expEntry_t   pending [$];                       // One entry per sampled edge
    int          checks = 0;
    int          errors = 0;

    assign checkCount = checks;
    assign errorCount = errors;

    function automatic string testName(input logic [3:0] id);
        case (id)
            4'd1:    return "resetContents";
            4'd2:    return "storeLoad";
            4'd3:    return "extension";
            4'd4:    return "misaligned";
            4'd5:    return "backToBack";
            default: return "reset";
        endcase
    endfunction

    // Shift the addressed lane down, then extend it by funct3
    function automatic logic [31:0] refLoad(input logic [31:0] word,
                                            input logic [1:0]  byteOff,
                                            input logic [2:0]  f3);
        logic [31:0] lane;
        lane = word >> {byteOff, 3'b000};
        case (f3)
            fnByte:  return {{24{lane[7]}}, lane[7:0]};
            fnHalf:  return {{16{lane[15]}}, lane[15:0]};
            fnWord:  return word;
            fnByteU: return {24'd0, lane[7:0]};
            fnHalfU: return {16'd0, lane[15:0]};
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] refStore(input logic [31:0] word,
                                             input logic [1:0]  byteOff,
                                             input logic [2:0]  f3,
                                             input logic [31:0] data);
        logic [31:0] mask;
        case (f3)
            fnByte:  mask = 32'h0000_00FF;
            fnHalf:  mask = 32'h0000_FFFF;
            default: mask = 32'hFFFF_FFFF;
        endcase
        mask = mask << {byteOff, 3'b000};
        return (word & ~mask) | ((data << {byteOff, 3'b000}) & mask);
    endfunction

    function automatic logic isMisaligned(input logic [1:0] byteOff, input logic [2:0] f3);
        case (f3)
            fnHalf, fnHalfU: return byteOff[0];
            fnWord:          return byteOff != 2'b00;
            default:         return 1'b0;
        endcase
    endfunction

    always @(posedge clk) begin : sampleRequest
        expEntry_t                entry;
        logic [31:0]              addr;
        logic [wordIndexBits-1:0] idx;
        entry        = '0;
        entry.testId = testId;
        addr         = baseAddr + offset;
        idx          = addr[wordIndexBits+1:2];
        if (reset) begin
            for (int i = 0; i < memWords; i++) begin
                shadow[i] = 32'(i + 3);
            end
        end else if (memWrite && (funct3 inside {fnByte, fnHalf, fnWord})) begin
            if (isMisaligned(addr[1:0], funct3)) begin
                entry.fault = 1'b1;                 // Memory left untouched
            end else begin
                shadow[idx] = refStore(shadow[idx], addr[1:0], funct3, storeData);
            end
        end else if (memRead && !memWrite &&
                     (funct3 inside {fnByte, fnHalf, fnWord, fnByteU, fnHalfU})) begin
            if (isMisaligned(addr[1:0], funct3)) begin
                entry.fault = 1'b1;
            end else begin
                entry.done = 1'b1;
                entry.data = refLoad(shadow[idx], addr[1:0], funct3);
                entry.inst = instNum;
                entry.phy  = phyIn;
            end
        end
        pending.push_back(entry);
    end

    task automatic compareField(input string       field,
                                input logic [3:0]  id,
                                input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("ERR %s %s: expected %h, actual %h", testName(id), field, expected, actual);
        end
    endtask

    // Outputs settle after the second edge, so compare mid cycle
    always @(negedge clk) begin : compareOutputs
        expEntry_t entry;
        if (pending.size() > 1) begin
            entry  = pending.pop_front();
            checks = checks + 1;
            compareField("loadDone", entry.testId, 32'(entry.done), 32'(loadDone));
            compareField("accessFault", entry.testId, 32'(entry.fault), 32'(accessFault));
            compareField("loadData", entry.testId, entry.data, loadData);
            compareField("loadInstNum", entry.testId, entry.inst, loadInstNum);
            compareField("loadPhy", entry.testId, {24'd0, entry.phy}, {24'd0, loadPhy});
        end
    end

endmodule

// ==== verif/lsuProperties.sv ====
module lsuProperties (
    input logic        clk,
    input logic        reset,
    input logic        validRead,
    input logic        validWrite,
    input logic        loadDone,
    input logic        accessFault
);
    int failCount = 0;

    doneNotWithFault: assert property (
        @(posedge clk) disable iff (reset) !(loadDone && accessFault)
    ) else begin
        failCount = failCount + 1;
        $error("loadDone and accessFault were high in the same cycle");
    end

    doneLowAfterReset: assert property (
        @(posedge clk) reset |=> !loadDone
    ) else begin
        failCount = failCount + 1;
        $error("loadDone was high in the cycle after reset");
    end

    strobesExclusive: assert property (
        @(posedge clk) disable iff (reset) !(validRead && validWrite)
    ) else begin
        failCount = failCount + 1;
        $error("Read and write strobes were high together");
    end

endmodule

// accessFault lives in the address stage, so the top level is the common scope
bind loadStoreUnit lsuProperties memProps (
    .clk         (clk),
    .reset       (reset),
    .validRead   (reqBus.validRead),
    .validWrite  (reqBus.validWrite),
    .loadDone    (loadDone),
    .accessFault (accessFault)
);

// ==== verif/lsuTb.sv ====
module lsuTb;
    import lsuPkg::*;

    localparam int clkPeriod    = 100;
    localparam int resetCycles  = 8;
    localparam int directedReqs = 26;
    localparam int randomReqs   = 300;
    localparam int drainReqs    = 3;
    localparam int watchdogTime =
        (resetCycles + directedReqs + randomReqs + drainReqs + 20) * clkPeriod;
    localparam logic [31:0] lfsrTaps = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1

    logic        clk = 1'b0;
    logic        reset;
    logic        memRead;
    logic        memWrite;
    logic [31:0] instNum;
    logic [2:0]  funct3;
    logic [31:0] baseAddr;
    logic [31:0] offset;
    logic [31:0] storeData;
    logic [7:0]  phyIn;
    logic [31:0] loadData;
    logic [31:0] loadInstNum;
    logic        loadDone;
    logic [7:0]  loadPhy;
    logic        accessFault;
    logic [3:0]  testId;
    logic [3:0]  activeTest;
    logic [31:0] nextInst  = 32'h0000_0100;
    logic [31:0] lfsrState = 32'h0513_3bce;
    int          checkCount;
    int          errorCount;

    loadStoreUnit dut0 (.*);

    lsuChecker scoreboard0 (.*);

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ lfsrTaps;
        end
        return shifted;
    endfunction

    task automatic drawBits(input int count, output logic [31:0] value);
        value = 32'd0;
        for (int i = 0; i < count; i++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic issue(input logic rd, input logic wr, input logic [2:0] f3,
                         input logic [31:0] base, input logic [31:0] off,
                         input logic [31:0] data, input logic [7:0] tag);
        @(posedge clk);
        #5;
        memRead   = rd;
        memWrite  = wr;
        funct3    = f3;
        baseAddr  = base;
        offset    = off;
        storeData = data;
        phyIn     = tag;
        instNum   = nextInst;
        testId    = activeTest;
        nextInst  = nextInst + 32'd1;
    endtask

    // Base and offset straddle the address so the adder carries
    task automatic loadReq(input logic [2:0] f3, input logic [31:0] addr);
        issue(1'b1, 1'b0, f3, addr + 32'h1000, 32'hFFFF_F000, ~addr, nextInst[7:0]);
    endtask

    task automatic storeReq(input logic [2:0] f3, input logic [31:0] addr, input logic [31:0] data);
        issue(1'b0, 1'b1, f3, addr + 32'h1000, 32'hFFFF_F000, data, nextInst[7:0]);
    endtask

    task automatic randomRequest();
        logic [31:0] kind;
        logic [31:0] f3Bits;
        logic [31:0] wordIdx;
        logic [31:0] byteOff;
        logic [31:0] hiBits;
        logic [31:0] data;
        logic [31:0] tag;
        logic [31:0] base;
        logic [31:0] target;
        drawBits(2, kind);
        drawBits(3, f3Bits);
        drawBits(4, wordIdx);                       // First 16 words only
        drawBits(2, byteOff);
        drawBits(2, hiBits);                        // Above the index, wraps away
        drawBits(32, data);
        drawBits(8, tag);
        drawBits(32, base);
        target = (hiBits << 10) | (wordIdx << 2) | byteOff;
        case (kind[1:0])
            2'd0, 2'd1: issue(1'b1, 1'b0, f3Bits[2:0], base, target - base, data, tag[7:0]);
            2'd2:       issue(1'b0, 1'b1, f3Bits[2:0], base, target - base, data, tag[7:0]);
            default:    issue(1'b0, 1'b0, f3Bits[2:0], base, target - base, data, tag[7:0]);
        endcase
    endtask

    initial begin : stimulus
        int w;
        reset      = 1'b1;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        instNum    = 32'd0;
        funct3     = 3'b000;
        baseAddr   = 32'd0;
        offset     = 32'd0;
        storeData  = 32'd0;
        phyIn      = 8'd0;
        testId     = 4'd0;
        activeTest = 4'd0;
        repeat (resetCycles) @(posedge clk);
        #5;
        reset = 1'b0;

        activeTest = 4'd1;                          // Untouched words 20 to 23
        for (w = 20; w < 24; w++) begin
            loadReq(fnWord, 32'(w * 4));
        end

        activeTest = 4'd2;
        storeReq(fnWord, 32'd120, 32'h1122_3344);
        loadReq(fnWord, 32'd120);
        storeReq(fnByte, 32'd121, 32'h0000_00AA);
        loadReq(fnWord, 32'd120);
        storeReq(fnHalf, 32'd122, 32'h0000_BEEF);
        loadReq(fnWord, 32'd120);

        activeTest = 4'd3;
        storeReq(fnWord, 32'd124, 32'h80F1_7F85);
        loadReq(fnByte, 32'd124);
        loadReq(fnByteU, 32'd124);
        loadReq(fnByte, 32'd125);
        loadReq(fnHalf, 32'd126);
        loadReq(fnHalfU, 32'd126);
        loadReq(fnHalf, 32'd124);
        loadReq(fnByte, 32'd127);
        loadReq(fnByteU, 32'd126);

        activeTest = 4'd4;
        storeReq(fnHalf, 32'd121, 32'h5555_5555);
        storeReq(fnWord, 32'd122, 32'h6666_6666);
        loadReq(fnHalf, 32'd123);
        loadReq(fnWord, 32'd121);
        loadReq(fnHalfU, 32'd125);
        loadReq(3'b011, 32'd120);                   // Unknown code, ignored
        loadReq(fnWord, 32'd120);                   // Still the old word

        activeTest = 4'd5;
        repeat (randomReqs) randomRequest();
        repeat (drainReqs) issue(1'b0, 1'b0, 3'b000, 32'd0, 32'd0, 32'd0, 8'd0);
        @(negedge clk);
        #1;                                         // After the last compare of this edge

        $display("Summary: %0d checks, %0d value errors, %0d assertion failures",
                 checkCount, errorCount, dut0.memProps.failCount);
        if (checkCount > 0 && errorCount == 0 && dut0.memProps.failCount == 0) begin
            $display("TEST OK");
        end else begin
            if (checkCount == 0) begin
                $display("No DUT output was ever compared");
            end
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdogTime);
        $display("Timeout: the stimulus did not finish within %0d time units", watchdogTime);
        $display("TEST FAILED");
        $finish;
    end

endmodule
